//--- design/regex_scan_defines.svh
`ifndef REGEX_SCAN_DEFINES_SVH
`define REGEX_SCAN_DEFINES_SVH

// Number of stream contexts held in the state memory
`define REGEX_SCAN_STREAMS 64

// Stream id width, enough to index every context
`define REGEX_SCAN_SID_W 6

// Packet match counter width, wraps on overflow
`define REGEX_SCAN_CNT_W 16

`endif

//--- design/regex_scan_pkg.sv
`default_nettype none

package regex_scan_pkg;

   // Automaton progress through the command word HELO
   // Two bits, stored unchanged in the per-stream context memory
   typedef enum logic [1:0]
   {
      // Nothing matched yet
      S_IDLE = 2'd0,
      // Seen H
      S_H    = 2'd1,
      // Seen HE
      S_HE   = 2'd2,
      // Seen HEL, an O completes the word
      S_HEL  = 2'd3
   } dfa_state_e;

   // Pattern characters, upper case ASCII only
   localparam logic [7:0] CH_H = 8'h48;
   localparam logic [7:0] CH_E = 8'h45;
   localparam logic [7:0] CH_L = 8'h4c;
   localparam logic [7:0] CH_O = 8'h4f;

endpackage

`default_nettype wire

//--- design/dfa_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dfa_if;
   import regex_scan_pkg::*;

   // Restore path, one-cycle strobe with the state to load
   dfa_state_e state_in;
   logic       state_in_vld;

   // Character path, passed through from the top level
   logic [7:0] char_in;
   logic       char_in_vld;

   // Current automaton state as a level, and the match pulse
   dfa_state_e state_out;
   logic       accept_out;

   // Context side drives restore and characters
   modport ctx (
      output state_in, state_in_vld, char_in, char_in_vld,
      input  state_out, accept_out
   );

   // Automaton side reports its state and matches
   modport dfa (
      input  state_in, state_in_vld, char_in, char_in_vld,
      output state_out, accept_out
   );

endinterface

`default_nettype wire

//--- design/pattern_dfa.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_dfa (
   input logic clk,
   input logic rst_n,
   dfa_if.dfa  dfa
);
   import regex_scan_pkg::*;

   // Automaton state register and the registered match pulse
   dfa_state_e state_q;
   logic       accept_q;

   // Result of the transition function for the current character
   dfa_state_e next_st;
   logic       hit;

   // Transition function for HELO
   // A mismatching H restarts at S_H, anything else drops to S_IDLE
   // No other overlap is possible, as HELO has no proper border
   always_comb
   begin
      next_st = S_IDLE;
      hit     = 1'b0;
      case (state_q)
         S_IDLE:
         begin
            if (dfa.char_in == CH_H)
               next_st = S_H;
         end
         S_H:
         begin
            if (dfa.char_in == CH_E)
               next_st = S_HE;
            else if (dfa.char_in == CH_H)
               next_st = S_H;
         end
         S_HE:
         begin
            if (dfa.char_in == CH_L)
               next_st = S_HEL;
            else if (dfa.char_in == CH_H)
               next_st = S_H;
         end
         S_HEL:
         begin
            // Final O, report the match and start over
            if (dfa.char_in == CH_O)
               hit = 1'b1;
            else if (dfa.char_in == CH_H)
               next_st = S_H;
         end
         default:
         begin
            next_st = S_IDLE;
         end
      endcase
   end

   // State update, a restore wins over a character in the same cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q  <= S_IDLE;
         accept_q <= 1'b0;
      end
      else
      begin
         // Pulse lasts one cycle unless another match follows
         accept_q <= 1'b0;
         if (dfa.state_in_vld)
            state_q <= dfa.state_in;
         else if (dfa.char_in_vld)
         begin
            state_q  <= next_st;
            accept_q <= hit;
         end
      end
   end

   // State is visible as a level for the save at end of packet
   assign dfa.state_out  = state_q;
   assign dfa.accept_out = accept_q;

endmodule

`default_nettype wire

//--- design/stream_context.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_scan_defines.svh"

module stream_context (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load_state,
   input  logic                         new_stream_id,
   input  logic                         eop,
   input  logic                         enable,
   input  logic                         char_in_vld,
   input  logic [`REGEX_SCAN_SID_W-1:0] stream_id,
   input  logic [7:0]                   char_in,
   output logic [`REGEX_SCAN_CNT_W-1:0] count,
   output logic                         fired,
   dfa_if.ctx                           dfa
);
   import regex_scan_pkg::*;

   // Saved automaton state, one entry per stream
   dfa_state_e state_mem [`REGEX_SCAN_STREAMS];

   // Restore register and its strobe toward the automaton
   dfa_state_e state_in_q;
   logic       state_in_vld_q;

   // Speculative match flag for the packet in progress
   logic spec_match;

   // Packet match counter
   logic [`REGEX_SCAN_CNT_W-1:0] count_q;

   // Save on an enabled end of packet
   logic save_en;

   assign save_en = eop & enable;

   // Context memory write, state as it stands at end of packet
   always_ff @(posedge clk)
   begin
      if (save_en)
         state_mem[stream_id] <= dfa.state_out;
   end

   // Restore value, fresh streams start from S_IDLE
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
            state_in_q <= S_IDLE;
         else
            state_in_q <= state_mem[stream_id];
      end
   end

   // Restore strobe, high for one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld_q <= 1'b0;
      else
         state_in_vld_q <= load_state;
   end

   // Match flag and counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_match <= 1'b0;
         count_q    <= '0;
      end
      else
      begin
         // New packet starts without a match
         if (load_state)
            spec_match <= 1'b0;

         // Any match within the packet sets the flag
         if (dfa.accept_out)
            spec_match <= 1'b1;

         if (eop)
         begin
            // Enabled stream commits the flag to the count
            if (enable)
               count_q <= count_q + {{(`REGEX_SCAN_CNT_W-1){1'b0}}, spec_match};
            else
               spec_match <= 1'b0;
         end
      end
   end

   assign dfa.state_in     = state_in_q;
   assign dfa.state_in_vld = state_in_vld_q;

   // Characters go straight to the automaton
   assign dfa.char_in     = char_in;
   assign dfa.char_in_vld = char_in_vld;

   assign count = count_q;
   assign fired = spec_match;

endmodule

`default_nettype wire

//--- design/regex_scan_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_scan_defines.svh"

module regex_scan_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load_state,
   input  logic                         new_stream_id,
   input  logic [`REGEX_SCAN_SID_W-1:0] stream_id,
   input  logic [7:0]                   char_in,
   input  logic                         char_in_vld,
   input  logic                         eop,
   input  logic                         enable,
   output logic [`REGEX_SCAN_CNT_W-1:0] count,
   output logic                         fired
);

   // Link between the context block and the automaton
   dfa_if dfa_i ();

   // Per-stream state, match flag and counter
   stream_context stream_context_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .eop           (eop),
      .enable        (enable),
      .char_in_vld   (char_in_vld),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .count         (count),
      .fired         (fired),
      .dfa           (dfa_i.ctx)
   );

   // HELO recognizer
   pattern_dfa pattern_dfa_i (
      .clk   (clk),
      .rst_n (rst_n),
      .dfa   (dfa_i.dfa)
   );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk
);

   // 20 ns period, starts low
   initial
   begin
      clk = 1'b0;
   end

   always #10 clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/regex_scan_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_scan_defines.svh"

module regex_scan_props (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         load_state,
   input logic                         eop,
   input logic                         enable,
   input logic [`REGEX_SCAN_CNT_W-1:0] count,
   input logic                         fired
);

   // Sticky failure flags, one per property
   logic reset_bad = 1'b0;
   logic clear_bad = 1'b0;
   logic count_bad = 1'b0;

   // Reset clears the counter and the match flag
   reset_clears: assert property (@(posedge clk) !rst_n |=> (count == '0 && !fired))
   else
   begin
      $error("mismatch at %0t: count or fired not cleared by reset", $time);
      reset_bad = 1'b1;
   end

   // New packet drops the match flag
   load_clears_fired: assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> !fired)
   else
   begin
      $error("mismatch at %0t: fired still high after load_state", $time);
      clear_bad = 1'b1;
   end

   // Counter moves only after an enabled eop, by one at most
   count_step: assert property (@(posedge clk) disable iff (!rst_n)
      (count != $past(count)) |->
         ($past(eop && enable) &&
          count == $past(count) + {{(`REGEX_SCAN_CNT_W-1){1'b0}}, 1'b1}))
   else
   begin
      $error("mismatch at %0t: count changed outside an enabled eop or by more than one",
             $time);
      count_bad = 1'b1;
   end

endmodule

`default_nettype wire

//--- testbench/regex_scan_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "regex_scan_defines.svh"

module regex_scan_tb;

   // Own copy of the command word for the reference model
   localparam logic [7:0] PATTERN [4] = '{"H", "E", "L", "O"};

   logic                         clk;
   logic                         rst_n;
   logic                         load_state;
   logic                         new_stream_id;
   logic [`REGEX_SCAN_SID_W-1:0] stream_id;
   logic [7:0]                   char_in;
   logic                         char_in_vld;
   logic                         eop;
   logic                         enable;
   logic [`REGEX_SCAN_CNT_W-1:0] count;
   logic                         fired;

   // Reference model, progress per stream and one total count
   int                           exp_prog [`REGEX_SCAN_STREAMS];
   bit                           seen [`REGEX_SCAN_STREAMS];
   logic [`REGEX_SCAN_CNT_W-1:0] exp_count;
   logic [7:0]                   pkt_bytes [$];

   tb_clock tb_clock_i (.clk(clk));

   regex_scan_top regex_scan_top_i (.*);

   bind regex_scan_top regex_scan_props regex_scan_props_i (.*);

   task automatic stop_with_failure();
      $display("Finished with errors");
      $fatal(1);
   endtask

   // One transition of HELO, 4 means the word just completed
   function automatic int step_model(input int prog, input logic [7:0] ch);
      if (ch == PATTERN[prog])
         return prog + 1;
      return (ch == PATTERN[0]) ? 1 : 0;
   endfunction

   // Random byte from H, E, L, O and X
   function automatic logic [7:0] pick_byte();
      case ($urandom_range(4))
         0: return "H";
         1: return "E";
         2: return "L";
         3: return "O";
         default: return "X";
      endcase
   endfunction

   task automatic load_text(input string s);
      int i;
      pkt_bytes.delete();
      for (i = 0; i < s.len(); i++)
         pkt_bytes.push_back(s[i]);
   endtask

   task automatic wait_fired();
      int cycles;
      cycles = 0;
      while (!fired && cycles < 8)
      begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (!fired)
      begin
         $display("fired never rose after a packet that holds HELO");
         stop_with_failure();
      end
   endtask

   // Restore, characters, then eop with the spacing rules
   task automatic send_packet(input int sid, input bit fresh, input bit en);
      int prog;
      bit hit;
      prog = fresh ? 0 : exp_prog[sid];
      hit  = 1'b0;
      load_state    = 1'b1;
      new_stream_id = fresh;
      stream_id     = sid[`REGEX_SCAN_SID_W-1:0];
      @(posedge clk);
      #2;
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      @(posedge clk);
      #2;
      foreach (pkt_bytes[i])
      begin
         char_in     = pkt_bytes[i];
         char_in_vld = 1'b1;
         prog        = step_model(prog, pkt_bytes[i]);
         if (prog == 4)
         begin
            hit  = 1'b1;
            prog = 0;
         end
         @(posedge clk);
         #2;
      end
      char_in_vld = 1'b0;
      @(posedge clk);
      #2;
      if (hit)
         wait_fired();
      assert (fired == hit)
      else
      begin
         $display("mismatch at %0t: fired %0b, expected %0b", $time, fired, hit);
         stop_with_failure();
      end
      eop    = 1'b1;
      enable = en;
      @(posedge clk);
      #2;
      eop    = 1'b0;
      enable = 1'b0;
      // Only enabled packets commit count and progress
      if (en)
      begin
         exp_count     = exp_count + {{(`REGEX_SCAN_CNT_W-1){1'b0}}, hit};
         exp_prog[sid] = prog;
         seen[sid]     = 1'b1;
      end
      assert (count == exp_count)
      else
      begin
         $display("mismatch at %0t: count %0d, expected %0d", $time, count, exp_count);
         stop_with_failure();
      end
      // Flag survives an enabled eop and is dropped by a disabled one
      assert (fired == (en && hit))
      else
      begin
         $display("mismatch at %0t: fired %0b after eop, expected %0b",
                  $time, fired, (en && hit));
         stop_with_failure();
      end
   endtask

   // Bound assertion flags end the run at once
   always @(posedge clk)
   begin
      if (regex_scan_top_i.regex_scan_props_i.reset_bad ||
          regex_scan_top_i.regex_scan_props_i.clear_bad ||
          regex_scan_top_i.regex_scan_props_i.count_bad)
      begin
         $display("A bound assertion on the DUT failed");
         stop_with_failure();
      end
   end

   initial
   begin
      int cycles;
      for (cycles = 0; cycles < 20000; cycles++)
         @(posedge clk);
      $display("Simulation timed out before the test sequence completed");
      stop_with_failure();
   end

   initial
   begin
      int sid;
      bit fresh;
      bit en;
      void'($urandom(32'h7e37));
      rst_n         = 1'b0;
      load_state    = 1'b0;
      new_stream_id = 1'b0;
      stream_id     = '0;
      char_in       = '0;
      char_in_vld   = 1'b0;
      eop           = 1'b0;
      enable        = 1'b0;
      exp_count     = '0;
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      assert (count == '0 && !fired)
      else
      begin
         $display("mismatch at %0t: count %0d fired %0b after reset", $time, count, fired);
         stop_with_failure();
      end

      // Single, double and HH-prefixed words
      load_text("HELO");
      send_packet(1, 1'b1, 1'b1);
      load_text("HELOXHELO");
      send_packet(2, 1'b1, 1'b1);
      load_text("HHELO");
      send_packet(3, 1'b1, 1'b1);

      // Word split over two packets, kept and then dropped by new_stream_id
      load_text("XXHE");
      send_packet(4, 1'b1, 1'b1);
      load_text("LOX");
      send_packet(4, 1'b0, 1'b1);
      load_text("XHE");
      send_packet(5, 1'b1, 1'b1);
      load_text("LO");
      send_packet(5, 1'b1, 1'b1);

      // Disabled packet neither counts nor saves its state
      load_text("HE");
      send_packet(6, 1'b1, 1'b1);
      load_text("LHELO");
      send_packet(6, 1'b0, 1'b0);
      load_text("LO");
      send_packet(6, 1'b0, 1'b1);

      // Interleaved random streams and bytes
      repeat (40)
      begin
         sid   = $urandom_range(7) * 9;
         fresh = !seen[sid] || ($urandom_range(4) == 0);
         en    = ($urandom_range(3) != 0);
         pkt_bytes.delete();
         repeat ($urandom_range(10, 1))
            pkt_bytes.push_back(pick_byte());
         send_packet(sid, fresh, en);
      end

      // Counter step of the last eop still has to be checked
      repeat (2) @(posedge clk);
      #2;

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/regex_scan_pkg.sv
design/dfa_if.sv
design/pattern_dfa.sv
design/stream_context.sv
design/regex_scan_top.sv
testbench/tb_clock.sv
testbench/regex_scan_props.sv
testbench/regex_scan_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = regex_scan_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
